/* design/host_l2_config.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host domain L2 configuration
// Bank count, bank depth and access wait states of the L2 memory path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef HOST_L2_CONFIG_SVH
`define HOST_L2_CONFIG_SVH

// Word-interleaved banks, one 32-bit word wide each
`define L2_NB_BANKS 4

// Words held by each bank
`define L2_BANK_WORDS 64

// Extra cycles before a bank read word is taken
`define L2_WAIT_CYCLES 2

`endif

/* design/host_l2_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host L2 package
// Data and address types, request structs and sequencer states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "host_l2_config.svh"

package host_l2_pkg;

  typedef logic [31:0] l2_word_t;
  typedef logic [63:0] l2_dword_t;

  // Host address selects a pair of words
  typedef logic [$clog2(`L2_NB_BANKS * `L2_BANK_WORDS / 2)-1:0] l2_dword_addr_t;
  typedef logic [$clog2(`L2_NB_BANKS * `L2_BANK_WORDS)-1:0]     l2_word_addr_t;

  typedef struct packed {
    l2_dword_addr_t addr;
    logic           we;
    l2_dword_t      wdata;
  } host_req_t;

  // One word access towards the banks
  typedef struct packed {
    l2_word_addr_t addr;
    logic          we;
    l2_word_t      wdata;
  } bank_cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    ACK
  } seq_state_e;

endpackage

`default_nettype wire

/* design/l2_access_seq.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 access sequencer
// Runs the four-phase host handshake and splits each 64-bit access
// into two 32-bit bank beats, low word first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_access_seq (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire host_l2_pkg::host_req_t host_req_i,
  input  wire logic                   host_req_valid_i,
  output logic                        host_ack_o,
  output host_l2_pkg::l2_dword_t      host_rdata_o,
  input  wire logic                   beat_i,
  input  wire logic                   wait_done_i,
  output logic                        timer_start_o,
  output host_l2_pkg::bank_cmd_t      bank_cmd_o,
  output logic                        bank_cmd_valid_o,
  input  wire host_l2_pkg::l2_word_t  bank_rdata_i
);

  host_l2_pkg::seq_state_e state_q;
  host_l2_pkg::seq_state_e state_d;
  host_l2_pkg::l2_dword_t  rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      host_l2_pkg::IDLE: begin
        if (host_req_valid_i) begin
          state_d = host_l2_pkg::ISSUE;
        end
      end
      host_l2_pkg::ISSUE: begin
        state_d = host_l2_pkg::WAIT;
      end
      host_l2_pkg::WAIT: begin
        // Beat 1 done means the whole dword is done
        if (wait_done_i) begin
          state_d = beat_i ? host_l2_pkg::ACK : host_l2_pkg::ISSUE;
        end
      end
      host_l2_pkg::ACK: begin
        if (!host_req_valid_i) begin
          state_d = host_l2_pkg::IDLE;
        end
      end
      default: state_d = host_l2_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= host_l2_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the read word into its half of the dword
  always_ff @(posedge clk_i) begin
    if (state_q == host_l2_pkg::WAIT && wait_done_i && !host_req_i.we) begin
      if (beat_i) begin
        rdata_q[63:32] <= bank_rdata_i;
      end else begin
        rdata_q[31:0] <= bank_rdata_i;
      end
    end
  end

  // Word address is the dword address with the beat as LSB
  always_comb begin
    bank_cmd_o.addr  = {host_req_i.addr, beat_i};
    bank_cmd_o.we    = host_req_i.we;
    bank_cmd_o.wdata = beat_i ? host_req_i.wdata[63:32] : host_req_i.wdata[31:0];
  end

  assign bank_cmd_valid_o = (state_q == host_l2_pkg::ISSUE);
  assign timer_start_o    = (state_q == host_l2_pkg::ISSUE);
  assign host_ack_o       = (state_q == host_l2_pkg::ACK);
  assign host_rdata_o     = rdata_q;

endmodule

`default_nettype wire

/* design/l2_beat_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 beat and wait-state timer
// Times the bank wait states of a beat and tracks the current beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "host_l2_config.svh"

module l2_beat_timer (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic start_i,
  output logic      beat_o,
  output logic      wait_done_o
);

  localparam int unsigned CNT_W = $clog2(`L2_WAIT_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             beat_q;

  // Down-counter that rests at zero when idle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_W'(`L2_WAIT_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - CNT_W'(1);
    end
  end

  // Last wait cycle before the counter reaches zero
  assign wait_done_o = (cnt_q == CNT_W'(1));

  // Toggles twice per access and ends at 0
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_q <= 1'b0;
    end else if (wait_done_o) begin
      beat_q <= ~beat_q;
    end
  end

  assign beat_o = beat_q;

endmodule

`default_nettype wire

/* design/l2_bank_array.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 bank array
// Word-interleaved 32-bit banks with address decode and a registered
// read mux, one access port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "host_l2_config.svh"

module l2_bank_array (
  input  wire logic                   clk_i,
  input  wire host_l2_pkg::bank_cmd_t bank_cmd_i,
  input  wire logic                   bank_cmd_valid_i,
  output host_l2_pkg::l2_word_t       bank_rdata_o
);

  localparam int unsigned BANK_BITS = $clog2(`L2_NB_BANKS);
  localparam int unsigned ROW_BITS  = $clog2(`L2_BANK_WORDS);

  host_l2_pkg::l2_word_t mem_q [`L2_NB_BANKS][`L2_BANK_WORDS];
  host_l2_pkg::l2_word_t rdata_q;

  logic [BANK_BITS-1:0] bank_sel;
  logic [ROW_BITS-1:0]  row_sel;

  // Consecutive words go to consecutive banks
  assign bank_sel = bank_cmd_i.addr[BANK_BITS-1:0];
  assign row_sel  = bank_cmd_i.addr[BANK_BITS +: ROW_BITS];

  always_ff @(posedge clk_i) begin
    if (bank_cmd_valid_i && bank_cmd_i.we) begin
      mem_q[bank_sel][row_sel] <= bank_cmd_i.wdata;
    end
  end

  // Read word held until the next read
  always_ff @(posedge clk_i) begin
    if (bank_cmd_valid_i && !bank_cmd_i.we) begin
      rdata_q <= mem_q[bank_sel][row_sel];
    end
  end

  assign bank_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* design/dma_evt_receiver.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cluster DMA event receiver
// Synchronizes the event request and turns each one into a pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module dma_evt_receiver (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic evt_req_i,
  output logic      evt_ack_o,
  output logic      evt_pulse_o
);

  logic sync1_q;
  logic sync2_q;
  logic edge_q;

  // Two-flop synchronizer, then edge register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      edge_q  <= 1'b0;
    end else begin
      sync1_q <= evt_req_i;
      sync2_q <= sync1_q;
      edge_q  <= sync2_q;
    end
  end

  // Ack mirrors the synchronized request level
  assign evt_ack_o   = sync2_q;
  assign evt_pulse_o = sync2_q & ~edge_q;

endmodule

`default_nettype wire

/* design/host_domain.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host domain top level
// 64-bit host path into the interleaved L2 banks and the cluster
// DMA event receiver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module host_domain (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire host_l2_pkg::host_req_t host_req_i,
  input  wire logic                   host_req_valid_i,
  output logic                        host_ack_o,
  output host_l2_pkg::l2_dword_t      host_rdata_o,
  input  wire logic                   evt_req_i,
  output logic                        evt_ack_o,
  output logic                        dma_evt_o
);

  host_l2_pkg::bank_cmd_t bank_cmd;
  logic                   bank_cmd_valid;
  host_l2_pkg::l2_word_t  bank_rdata;
  logic                   timer_start;
  logic                   beat;
  logic                   wait_done;

  l2_access_seq i_access_seq (
    .clk_i            ( clk_i            ),
    .reset_i          ( reset_i          ),
    .host_req_i       ( host_req_i       ),
    .host_req_valid_i ( host_req_valid_i ),
    .host_ack_o       ( host_ack_o       ),
    .host_rdata_o     ( host_rdata_o     ),
    .beat_i           ( beat             ),
    .wait_done_i      ( wait_done        ),
    .timer_start_o    ( timer_start      ),
    .bank_cmd_o       ( bank_cmd         ),
    .bank_cmd_valid_o ( bank_cmd_valid   ),
    .bank_rdata_i     ( bank_rdata       )
  );

  l2_beat_timer i_beat_timer (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .start_i     ( timer_start ),
    .beat_o      ( beat        ),
    .wait_done_o ( wait_done   )
  );

  l2_bank_array i_bank_array (
    .clk_i            ( clk_i          ),
    .bank_cmd_i       ( bank_cmd       ),
    .bank_cmd_valid_i ( bank_cmd_valid ),
    .bank_rdata_o     ( bank_rdata     )
  );

  // Cluster DMA event into the host domain
  dma_evt_receiver i_dma_evt_rx (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .evt_req_i   ( evt_req_i ),
    .evt_ack_o   ( evt_ack_o ),
    .evt_pulse_o ( dma_evt_o )
  );

endmodule

`default_nettype wire

/* bench/tb_host_domain.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host domain testbench
// LFSR driven 64-bit L2 accesses against a reference model, four-phase
// handshake checks and the cluster DMA event path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_host_domain;

  localparam logic [31:0] SEED           = 32'hb9c9_c63a;
  localparam int          ACK_TIMEOUT    = 50;
  localparam int          EVT_TIMEOUT    = 10;
  localparam int          RAND_OPS       = 200;
  localparam int          EVT_HANDSHAKES = 20;

  logic                   clk;
  logic                   reset;
  host_l2_pkg::host_req_t host_req;
  logic                   host_req_valid;
  logic                   host_ack;
  host_l2_pkg::l2_dword_t host_rdata;
  logic                   evt_req;
  logic                   evt_ack;
  logic                   dma_evt;

  // Reference model with one entry per 64-bit host item
  host_l2_pkg::l2_dword_t ref_mem [128];
  logic                   ref_valid [128];

  // Expectation of the access in flight
  logic                       exp_is_read;
  host_l2_pkg::l2_dword_addr_t exp_addr;
  host_l2_pkg::l2_dword_t     exp_rdata;

  logic [31:0] lfsr_state;
  int          evt_pulse_count;
  logic        ack_prev;
  logic        valid_prev;
  logic        evt_ack_prev;
  logic        evt_req_prev;
  logic        pulse_prev;

  host_domain dut_i (
    .clk_i            ( clk            ),
    .reset_i          ( reset          ),
    .host_req_i       ( host_req       ),
    .host_req_valid_i ( host_req_valid ),
    .host_ack_o       ( host_ack       ),
    .host_rdata_o     ( host_rdata     ),
    .evt_req_i        ( evt_req        ),
    .evt_ack_o        ( evt_ack        ),
    .dma_evt_o        ( dma_evt        )
  );

  always #2 clk = ~clk;

  task automatic report_mismatch(input string msg);
    $display("FAILED at time %0d ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at time %0d ns: %s", $time, what);
    $display("Test failed");
    $fatal(1, "Stopped on a timeout");
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[62:0], lfsr_state[0]};
    end
  endtask

  // Latest value written to a host item
  function automatic host_l2_pkg::l2_dword_t expected_rdata(
    input host_l2_pkg::l2_dword_addr_t addr
  );
    return ref_mem[addr];
  endfunction

  // One four-phase access with valid held hold extra cycles after ack
  task automatic host_access(input host_l2_pkg::l2_dword_addr_t addr, input logic we,
                             input host_l2_pkg::l2_dword_t wdata, input int hold);
    int waited;
    host_req.addr  = addr;
    host_req.we    = we;
    host_req.wdata = wdata;
    exp_is_read    = !we;
    exp_addr       = addr;
    exp_rdata      = expected_rdata(addr);
    host_req_valid = 1'b1;
    waited = 0;
    while (!host_ack) begin
      if (waited == ACK_TIMEOUT) begin
        report_timeout("host ack did not rise for a request");
      end
      @(negedge clk);
      waited++;
    end
    repeat (hold) @(negedge clk);
    host_req_valid = 1'b0;
    if (we) begin
      ref_mem[addr]   = wdata;
      ref_valid[addr] = 1'b1;
    end
    waited = 0;
    while (host_ack) begin
      if (waited == ACK_TIMEOUT) begin
        report_timeout("host ack did not fall after valid dropped");
      end
      @(negedge clk);
      waited++;
    end
    assert (waited == 1)
      else report_mismatch($sformatf("host ack fell %0d cycles after valid", waited));
  endtask

  task automatic write_then_read(input host_l2_pkg::l2_dword_addr_t addr);
    logic [63:0] data;
    draw_bits(64, data);
    host_access(addr, 1'b1, data, 0);
    host_access(addr, 1'b0, '0, 0);
  endtask

  task automatic event_handshake(input int index);
    int          waited;
    logic [63:0] gap;
    evt_req = 1'b1;
    waited = 0;
    while (!evt_ack) begin
      if (waited == EVT_TIMEOUT) begin
        report_timeout("event ack did not rise after the request");
      end
      @(negedge clk);
      waited++;
    end
    assert (waited >= 2 && waited <= 3)
      else report_mismatch($sformatf("event ack rose after %0d cycles", waited));
    evt_req = 1'b0;
    waited = 0;
    while (evt_ack) begin
      if (waited == EVT_TIMEOUT) begin
        report_timeout("event ack did not fall after the request dropped");
      end
      @(negedge clk);
      waited++;
    end
    assert (evt_pulse_count == index + 1)
      else report_mismatch($sformatf("%0d event pulses after %0d handshakes",
                                     evt_pulse_count, index + 1));
    draw_bits(3, gap);
    repeat (int'(gap[2:0])) @(negedge clk);
  endtask

  // Compare process sampling DUT outputs at the rising edge
  always @(posedge clk) begin
    if (reset) begin
      ack_prev        <= 1'b0;
      valid_prev      <= 1'b0;
      evt_ack_prev    <= 1'b0;
      evt_req_prev    <= 1'b0;
      pulse_prev      <= 1'b0;
      evt_pulse_count <= 0;
    end else begin
      // Inputs as the DUT saw them at the previous edge
      if (host_ack && !ack_prev) begin
        assert (valid_prev) else report_mismatch("host ack rose without a request");
      end
      if (ack_prev && valid_prev) begin
        assert (host_ack) else report_mismatch("host ack dropped while valid was high");
      end
      if (host_ack && exp_is_read) begin
        assert (host_rdata == exp_rdata)
          else report_mismatch($sformatf("read of item %0d gave %h, expected %h",
                                         exp_addr, host_rdata, exp_rdata));
      end
      if (dma_evt) begin
        evt_pulse_count <= evt_pulse_count + 1;
        assert (!pulse_prev) else report_mismatch("dma event pulse longer than one cycle");
        assert (evt_ack) else report_mismatch("dma event pulse without event ack");
      end
      if (evt_ack && !evt_ack_prev) begin
        assert (evt_req_prev) else report_mismatch("event ack rose without a request");
      end
      if (!evt_ack && evt_ack_prev) begin
        assert (!evt_req_prev) else report_mismatch("event ack fell while request was high");
      end
      ack_prev     <= host_ack;
      valid_prev   <= host_req_valid;
      evt_ack_prev <= evt_ack;
      evt_req_prev <= evt_req;
      pulse_prev   <= dma_evt;
    end
  end

  initial begin
    int                          op;
    logic [63:0]                 bits;
    host_l2_pkg::l2_dword_addr_t addr;
    logic                        we;
    host_l2_pkg::l2_dword_t      wdata;
    int                          hold;
    clk            = 1'b0;
    reset          = 1'b1;
    host_req       = '0;
    host_req_valid = 1'b0;
    evt_req        = 1'b0;
    exp_is_read    = 1'b0;
    exp_addr       = '0;
    exp_rdata      = '0;
    lfsr_state     = SEED;
    for (op = 0; op < 128; op++) begin
      ref_mem[op]   = '0;
      ref_valid[op] = 1'b0;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;
    assert (!host_ack && !evt_ack && !dma_evt)
      else report_mismatch("outputs not low after reset");
    // Idle period without requests
    repeat (10) @(negedge clk);

    // Corner items and items that cover all four banks
    write_then_read(7'd0);
    write_then_read(7'd1);
    write_then_read(7'd2);
    write_then_read(7'd3);
    write_then_read(7'd127);

    for (op = 0; op < RAND_OPS; op++) begin
      draw_bits(7, bits);
      addr = bits[6:0];
      draw_bits(1, bits);
      we = bits[0];
      // Unwritten items are written first
      if (!ref_valid[addr]) begin
        we = 1'b1;
      end
      draw_bits(64, bits);
      wdata = bits;
      draw_bits(3, bits);
      hold = int'(bits[2:0]) % 6;
      host_access(addr, we, wdata, hold);
    end

    for (op = 0; op < EVT_HANDSHAKES; op++) begin
      event_handshake(op);
    end
    repeat (4) @(negedge clk);
    assert (evt_pulse_count == EVT_HANDSHAKES)
      else report_mismatch($sformatf("%0d event pulses for %0d handshakes",
                                     evt_pulse_count, EVT_HANDSHAKES));
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/host_l2_pkg.sv
design/l2_access_seq.sv
design/l2_beat_timer.sv
design/l2_bank_array.sv
design/dma_evt_receiver.sv
design/host_domain.sv
bench/tb_host_domain.sv

/* run.sh */
#!/bin/sh
# Build and run the host domain testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f src.f \
  --top-module tb_host_domain \
  -o sim_host_domain

# Simulation output decides pass or fail
out=$(./obj_dir/sim_host_domain) || true
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
  exit 0
fi
exit 1
